// File: rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int word_width         = 8;
    localparam int reg_index_width    = 2;
    localparam int opcode_width       = 4;
    localparam int alu_function_width = 3;
    localparam int write_source_width = 2;

    // Opcodes, 0111 and 1000 left free
    localparam logic [opcode_width-1:0] op_and = 4'b0000;
    localparam logic [opcode_width-1:0] op_or  = 4'b0001;
    localparam logic [opcode_width-1:0] op_not = 4'b0010;
    localparam logic [opcode_width-1:0] op_add = 4'b0011;
    localparam logic [opcode_width-1:0] op_sub = 4'b0100;
    localparam logic [opcode_width-1:0] op_lsr = 4'b0101;
    localparam logic [opcode_width-1:0] op_lsl = 4'b0110;
    localparam logic [opcode_width-1:0] op_bra = 4'b1001;
    localparam logic [opcode_width-1:0] op_bne = 4'b1010;
    localparam logic [opcode_width-1:0] op_mov = 4'b1011;
    localparam logic [opcode_width-1:0] op_ld  = 4'b1100;
    localparam logic [opcode_width-1:0] op_st  = 4'b1101;

    localparam logic [alu_function_width-1:0] alu_and  = 3'd0;
    localparam logic [alu_function_width-1:0] alu_or   = 3'd1;
    localparam logic [alu_function_width-1:0] alu_not  = 3'd2;
    localparam logic [alu_function_width-1:0] alu_add  = 3'd3;
    localparam logic [alu_function_width-1:0] alu_sub  = 3'd4;
    localparam logic [alu_function_width-1:0] alu_lsr  = 3'd5;
    localparam logic [alu_function_width-1:0] alu_lsl  = 3'd6;
    localparam logic [alu_function_width-1:0] alu_pass = 3'd7;

    localparam logic [write_source_width-1:0] src_alu       = 2'd0;
    localparam logic [write_source_width-1:0] src_memory    = 2'd1;
    localparam logic [write_source_width-1:0] src_immediate = 2'd2;

    localparam logic mode_direct = 1'b1;

    // One instruction word, two views
    typedef union packed {
        struct packed {
            logic [opcode_width-1:0] opcode;
            logic [3:0]              destination;
            logic [3:0]              source_one;
            logic [3:0]              source_two;
        } reg_form;
        struct packed {
            logic [opcode_width-1:0] opcode;
            logic                    spare;
            logic                    mode;        // 1 = direct
            logic [1:0]              reg_select;
            logic [word_width-1:0]   address;
        } addr_form;
    } ir_word_t;

endpackage

`default_nettype wire

// File: rtl/control_unit.sv
`timescale 1ns/10ps
`default_nettype none

module control_unit import cpu_pkg::*; (
    input  wire logic                          clock,
    input  wire logic                          arst_n,
    input  wire ir_word_t                      ir,
    input  wire logic                          zero,
    output logic                               ir_load_low,
    output logic                               ir_load_high,
    output logic                               pc_increment,
    output logic                               pc_load,
    output logic                               ar_load,
    output logic                               address_from_ar,
    output logic                               rf_write,
    output logic                               mem_write,
    output logic [reg_index_width-1:0]         rf_write_sel,
    output logic [reg_index_width-1:0]         rf_read_a,
    output logic [reg_index_width-1:0]         rf_read_b,
    output logic [write_source_width-1:0]      rf_write_source,
    output logic [alu_function_width-1:0]      alu_function,
    output logic                               flag_write
);

    logic [1:0] step;
    logic       last_step;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            step <= 2'd0;
        end else if (last_step) begin
            step <= 2'd0;
        end else begin
            step <= step + 2'd1;
        end
    end

    always_comb begin
        ir_load_low     = 1'b0;
        ir_load_high    = 1'b0;
        pc_increment    = 1'b0;
        pc_load         = 1'b0;
        ar_load         = 1'b0;
        address_from_ar = 1'b0;
        rf_write        = 1'b0;
        mem_write       = 1'b0;
        rf_write_sel    = '0;
        rf_read_a       = '0;
        rf_read_b       = '0;
        rf_write_source = src_alu;
        alu_function    = alu_pass;
        flag_write      = 1'b0;
        last_step       = 1'b0;

        case (step)
            2'd0: begin // T0 low byte
                ir_load_low  = 1'b1;
                pc_increment = 1'b1;
            end
            2'd1: begin // T1 high byte
                ir_load_high = 1'b1;
                pc_increment = 1'b1;
            end
            2'd2: begin
                case (ir.reg_form.opcode)
                    op_and, op_or, op_not, op_add, op_sub, op_lsr, op_lsl, op_mov: begin
                        rf_read_a       = ir.reg_form.source_one[reg_index_width-1:0];
                        rf_read_b       = ir.reg_form.source_two[reg_index_width-1:0];
                        rf_write_sel    = ir.reg_form.destination[reg_index_width-1:0];
                        rf_write_source = src_alu;
                        rf_write        = 1'b1;
                        flag_write      = 1'b1;
                        last_step       = 1'b1;
                        case (ir.reg_form.opcode)
                            op_and:  alu_function = alu_and;
                            op_or:   alu_function = alu_or;
                            op_not:  alu_function = alu_not;
                            op_add:  alu_function = alu_add;
                            op_sub:  alu_function = alu_sub;
                            op_lsr:  alu_function = alu_lsr;
                            op_lsl:  alu_function = alu_lsl;
                            default: alu_function = alu_pass; // MOV
                        endcase
                    end
                    op_ld: begin
                        if (ir.addr_form.mode == mode_direct) begin
                            ar_load = 1'b1;
                        end else begin
                            rf_write_sel    = ir.addr_form.reg_select;
                            rf_write_source = src_immediate;
                            rf_write        = 1'b1;
                            last_step       = 1'b1;
                        end
                    end
                    op_st: begin
                        ar_load = 1'b1;
                    end
                    op_bra: begin
                        pc_load   = 1'b1;
                        last_step = 1'b1;
                    end
                    op_bne: begin
                        pc_load   = !zero;
                        last_step = 1'b1;
                    end
                    default: begin
                        last_step = 1'b1; // Free codes act as no-op
                    end
                endcase
            end
            default: begin // T3, memory access through AR
                address_from_ar = 1'b1;
                last_step       = 1'b1;
                if (ir.addr_form.opcode == op_st) begin
                    rf_read_b = ir.addr_form.reg_select;
                    mem_write = 1'b1;
                end else begin
                    rf_write_sel    = ir.addr_form.reg_select;
                    rf_write_source = src_memory;
                    rf_write        = 1'b1;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit import cpu_pkg::*; (
    input  wire logic                  clock,
    input  wire logic                  arst_n,
    input  wire logic                  ir_load_low,
    input  wire logic                  ir_load_high,
    input  wire logic                  pc_increment,
    input  wire logic                  pc_load,
    input  wire logic                  ar_load,
    input  wire logic                  address_from_ar,
    input  wire logic [word_width-1:0] mem_rdata,
    output ir_word_t                   ir,
    output logic [word_width-1:0]      mem_address
);

    logic [word_width-1:0] pc;
    logic [word_width-1:0] ar;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (pc_load) begin
            pc <= ir.addr_form.address; // Branch target
        end else if (pc_increment) begin
            pc <= pc + word_width'(1);
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ar <= '0;
        end else if (ar_load) begin
            ar <= ir.addr_form.address;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ir <= '0;
        end else begin
            if (ir_load_low) begin
                ir[word_width-1:0] <= mem_rdata;
            end
            if (ir_load_high) begin
                ir[2*word_width-1:word_width] <= mem_rdata; // Opcode byte
            end
        end
    end

    assign mem_address = address_from_ar ? ar : pc;

endmodule

`default_nettype wire

// File: rtl/register_file.sv
`timescale 1ns/10ps
`default_nettype none

module register_file import cpu_pkg::*; (
    input  wire logic                          clock,
    input  wire logic                          arst_n,
    input  wire logic                          rf_write,
    input  wire logic [reg_index_width-1:0]    rf_write_sel,
    input  wire logic [write_source_width-1:0] rf_write_source,
    input  wire logic [reg_index_width-1:0]    rf_read_a,
    input  wire logic [reg_index_width-1:0]    rf_read_b,
    input  wire logic [word_width-1:0]         alu_result,
    input  wire logic [word_width-1:0]         mem_rdata,
    input  wire logic [word_width-1:0]         immediate,
    output logic [word_width-1:0]              read_a,
    output logic [word_width-1:0]              read_b
);

    logic [word_width-1:0] regs [2**reg_index_width]; // R1 to R4
    logic [word_width-1:0] write_data;

    always_comb begin
        case (rf_write_source)
            src_memory:    write_data = mem_rdata;
            src_immediate: write_data = immediate;
            default:       write_data = alu_result;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**reg_index_width; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_write) begin
            regs[rf_write_sel] <= write_data;
        end
    end

    assign read_a = regs[rf_read_a];
    assign read_b = regs[rf_read_b];

endmodule

`default_nettype wire

// File: rtl/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu import cpu_pkg::*; (
    input  wire logic                          clock,
    input  wire logic                          arst_n,
    input  wire logic [alu_function_width-1:0] alu_function,
    input  wire logic                          flag_write,
    input  wire logic [word_width-1:0]         operand_a,
    input  wire logic [word_width-1:0]         operand_b,
    output logic [word_width-1:0]              result,
    output logic                               zero
);

    always_comb begin
        case (alu_function)
            alu_and: begin
                result = operand_a & operand_b;
            end
            alu_or: begin
                result = operand_a | operand_b;
            end
            alu_not: begin
                result = ~operand_a;
            end
            alu_add: begin
                result = operand_a + operand_b; // Carry dropped
            end
            alu_sub: begin
                result = operand_a - operand_b;
            end
            alu_lsr: begin
                result = operand_a >> 1;
            end
            alu_lsl: begin
                result = operand_a << 1;
            end
            default: begin
                result = operand_a; // Pass for MOV
            end
        endcase
    end

    // Only flag kept, read by BNE
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            zero <= 1'b0;
        end else if (flag_write) begin
            zero <= (result == '0);
        end
    end

endmodule

`default_nettype wire

// File: rtl/cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
    input  wire logic                  clock,
    input  wire logic                  arst_n,
    input  wire logic [word_width-1:0] mem_rdata,
    output logic [word_width-1:0]      mem_address,
    output logic [word_width-1:0]      mem_wdata,
    output logic                       mem_write
);

    ir_word_t                        ir;
    logic                            zero;
    logic                            ir_load_low;
    logic                            ir_load_high;
    logic                            pc_increment;
    logic                            pc_load;
    logic                            ar_load;
    logic                            address_from_ar;
    logic                            rf_write;
    logic [reg_index_width-1:0]      rf_write_sel;
    logic [reg_index_width-1:0]      rf_read_a;
    logic [reg_index_width-1:0]      rf_read_b;
    logic [write_source_width-1:0]   rf_write_source;
    logic [alu_function_width-1:0]   alu_function;
    logic                            flag_write;
    logic [word_width-1:0]           read_a;
    logic [word_width-1:0]           read_b;
    logic [word_width-1:0]           alu_result;

    control_unit control_unit_inst (
        .clock           (clock),
        .arst_n          (arst_n),
        .ir              (ir),
        .zero            (zero),
        .ir_load_low     (ir_load_low),
        .ir_load_high    (ir_load_high),
        .pc_increment    (pc_increment),
        .pc_load         (pc_load),
        .ar_load         (ar_load),
        .address_from_ar (address_from_ar),
        .rf_write        (rf_write),
        .mem_write       (mem_write),
        .rf_write_sel    (rf_write_sel),
        .rf_read_a       (rf_read_a),
        .rf_read_b       (rf_read_b),
        .rf_write_source (rf_write_source),
        .alu_function    (alu_function),
        .flag_write      (flag_write)
    );

    fetch_unit fetch_unit_inst (
        .clock           (clock),
        .arst_n          (arst_n),
        .ir_load_low     (ir_load_low),
        .ir_load_high    (ir_load_high),
        .pc_increment    (pc_increment),
        .pc_load         (pc_load),
        .ar_load         (ar_load),
        .address_from_ar (address_from_ar),
        .mem_rdata       (mem_rdata),
        .ir              (ir),
        .mem_address     (mem_address)
    );

    register_file register_file_inst (
        .clock           (clock),
        .arst_n          (arst_n),
        .rf_write        (rf_write),
        .rf_write_sel    (rf_write_sel),
        .rf_write_source (rf_write_source),
        .rf_read_a       (rf_read_a),
        .rf_read_b       (rf_read_b),
        .alu_result      (alu_result),
        .mem_rdata       (mem_rdata),
        .immediate       (ir.addr_form.address), // LD immediate value
        .read_a          (read_a),
        .read_b          (read_b)
    );

    alu alu_inst (
        .clock        (clock),
        .arst_n       (arst_n),
        .alu_function (alu_function),
        .flag_write   (flag_write),
        .operand_a    (read_a),
        .operand_b    (read_b),
        .result       (alu_result),
        .zero         (zero)
    );

    assign mem_wdata = read_b; // Store data from port B

endmodule

`default_nettype wire

// File: bench/cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    localparam int test_cycles   = 175; // Reset plus program cycles of all tests
    localparam int timeout_limit = 2 * test_cycles;

    logic                  clock;
    logic                  arst_n;
    logic [word_width-1:0] mem_rdata;
    logic [word_width-1:0] mem_address;
    logic [word_width-1:0] mem_wdata;
    logic                  mem_write;

    logic [word_width-1:0] mem [256];
    logic [word_width-1:0] store_addr_q [$];
    logic [word_width-1:0] store_data_q [$];
    logic [word_width-1:0] expect_addr_q [$];
    logic [word_width-1:0] expect_data_q [$];
    logic [15:0]           lfsr_state;
    logic [word_width-1:0] fill_ptr;
    int                    program_cycles;
    logic                  path_on; // Low while placing code the CPU skips
    int                    cycle_count;

    cpu_top cpu_top_inst (
        .clock       (clock),
        .arst_n      (arst_n),
        .mem_rdata   (mem_rdata),
        .mem_address (mem_address),
        .mem_wdata   (mem_wdata),
        .mem_write   (mem_write)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    assign mem_rdata = mem[mem_address]; // Asynchronous read

    always @(posedge clock) begin
        if (arst_n && mem_write) begin
            store_addr_q.push_back(mem_address);
            store_data_q.push_back(mem_wdata);
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout: the run went past %0d cycles", timeout_limit);
            $display("Test failed");
            $fatal(1);
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_address(input logic [word_width-1:0] expected,
                                 input logic [word_width-1:0] actual, input string name);
        if (actual !== expected) begin
            fail_run($sformatf("Error at %0d ns: %s expected 0x%02h, got 0x%02h",
                               $time, name, expected, actual));
        end
    endtask

    task automatic check_data(input logic [word_width-1:0] expected,
                              input logic [word_width-1:0] actual, input string name);
        if (actual !== expected) begin
            fail_run($sformatf("Error at %0d ns: %s expected 0x%02h, got 0x%02h",
                               $time, name, expected, actual));
        end
    endtask

    task automatic check_write(input logic expected, input logic actual, input string name);
        if (actual !== expected) begin
            fail_run($sformatf("Error at %0d ns: %s expected %b, got %b",
                               $time, name, expected, actual));
        end
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        lfsr_next = state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
    endfunction

    task automatic random_byte(output logic [word_width-1:0] value);
        for (int i = 0; i < word_width; i++) begin
            value = {value[word_width-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic new_program();
        for (int i = 0; i < 256; i++) begin
            mem[8'(i)] = 8'(i * 7) ^ 8'h3c; // Filler that is never executed
        end
        fill_ptr       = '0;
        program_cycles = 0;
        path_on        = 1'b1;
        expect_addr_q.delete();
        expect_data_q.delete();
    endtask

    task automatic place_word(input ir_word_t word);
        mem[fill_ptr]         = word[word_width-1:0];           // Low byte first
        mem[fill_ptr + 8'd1]  = word[2*word_width-1:word_width];
        fill_ptr              = fill_ptr + 8'd2;
    endtask

    task automatic alu_instruction(input logic [opcode_width-1:0] opcode,
                                   input logic [1:0] dest, input logic [1:0] src_one,
                                   input logic [1:0] src_two);
        ir_word_t word;
        word                        = '0;
        word.reg_form.opcode        = opcode;
        word.reg_form.destination   = {2'b00, dest};
        word.reg_form.source_one    = {2'b00, src_one};
        word.reg_form.source_two    = {2'b00, src_two};
        place_word(word);
        if (path_on) program_cycles += 3;
    endtask

    task automatic address_instruction(input logic [opcode_width-1:0] opcode,
                                       input logic mode, input logic [1:0] sel,
                                       input logic [word_width-1:0] address, input int cycles);
        ir_word_t word;
        word                      = '0;
        word.addr_form.opcode     = opcode;
        word.addr_form.mode       = mode;
        word.addr_form.reg_select = sel;
        word.addr_form.address    = address;
        place_word(word);
        if (path_on) program_cycles += cycles;
    endtask

    task automatic load_immediate(input logic [1:0] sel, input logic [word_width-1:0] value);
        address_instruction(op_ld, 1'b0, sel, value, 3);
    endtask

    task automatic load_direct(input logic [1:0] sel, input logic [word_width-1:0] address);
        address_instruction(op_ld, mode_direct, sel, address, 4);
    endtask

    task automatic store_register(input logic [1:0] sel, input logic [word_width-1:0] address,
                                  input logic [word_width-1:0] expected);
        address_instruction(op_st, mode_direct, sel, address, 4);
        if (path_on) begin
            expect_addr_q.push_back(address);
            expect_data_q.push_back(expected);
        end
    endtask

    task automatic branch_always(input logic [word_width-1:0] target);
        address_instruction(op_bra, 1'b0, 2'd0, target, 3);
    endtask

    task automatic branch_not_zero(input logic [word_width-1:0] target);
        address_instruction(op_bne, 1'b0, 2'd0, target, 3);
    endtask

    task automatic apply_reset();
        @(negedge clock);
        arst_n = 1'b0;
        store_addr_q.delete();
        store_data_q.delete();
        repeat (5) @(negedge clock);
        arst_n = 1'b1;
    endtask

    task automatic run_program();
        apply_reset();
        repeat (program_cycles) @(posedge clock);
        @(negedge clock);
        if (store_addr_q.size() != expect_addr_q.size()) begin
            fail_run($sformatf("The CPU made %0d stores where %0d were expected",
                               store_addr_q.size(), expect_addr_q.size()));
        end
        for (int i = 0; i < expect_addr_q.size(); i++) begin
            check_address(expect_addr_q[i], store_addr_q[i], "mem_address");
            check_data(expect_data_q[i], store_data_q[i], "mem_wdata");
        end
    endtask

    task automatic reset_fetch_test();
        new_program();
        apply_reset();
        check_address(8'h00, mem_address, "mem_address"); // T0 reads PC 0
        check_write(1'b0, mem_write, "mem_write");
        @(negedge clock);
        check_address(8'h01, mem_address, "mem_address");
        check_write(1'b0, mem_write, "mem_write");
    endtask

    task automatic load_store_test();
        logic [word_width-1:0] values [4];
        new_program();
        for (int r = 0; r < 4; r++) begin
            random_byte(values[r]);
            load_immediate(2'(r), values[r]);
        end
        for (int r = 0; r < 4; r++) begin
            store_register(2'(r), 8'hc0 + 8'(r), values[r]);
        end
        run_program();
    endtask

    task automatic alu_test();
        logic [word_width-1:0] a;
        logic [word_width-1:0] b;
        random_byte(a);
        random_byte(b);
        new_program();
        load_immediate(2'd0, a);
        load_immediate(2'd1, b);
        alu_instruction(op_and, 2'd2, 2'd0, 2'd1);
        store_register(2'd2, 8'hd0, a & b);
        alu_instruction(op_or, 2'd2, 2'd0, 2'd1);
        store_register(2'd2, 8'hd1, a | b);
        alu_instruction(op_not, 2'd2, 2'd0, 2'd1);
        store_register(2'd2, 8'hd2, ~a);
        alu_instruction(op_add, 2'd2, 2'd0, 2'd1);
        store_register(2'd2, 8'hd3, a + b);
        alu_instruction(op_sub, 2'd2, 2'd0, 2'd1);
        store_register(2'd2, 8'hd4, a - b); // Wraps modulo 256
        alu_instruction(op_lsr, 2'd2, 2'd0, 2'd1);
        store_register(2'd2, 8'hd5, a >> 1);
        alu_instruction(op_lsl, 2'd2, 2'd0, 2'd1);
        store_register(2'd2, 8'hd6, a << 1);
        alu_instruction(op_mov, 2'd3, 2'd0, 2'd1);
        store_register(2'd3, 8'hd7, a);
        run_program();
    endtask

    task automatic direct_load_test();
        logic [word_width-1:0] preset;
        random_byte(preset);
        new_program();
        mem[8'he0] = preset;
        load_direct(2'd1, 8'he0);
        store_register(2'd1, 8'he8, preset);
        run_program();
    endtask

    task automatic branch_test();
        logic [word_width-1:0] v;
        random_byte(v);
        new_program();
        load_immediate(2'd0, 8'h11);
        branch_always(fill_ptr + 8'd4); // Over one instruction
        path_on = 1'b0;
        store_register(2'd0, 8'hf0, 8'h11);
        path_on = 1'b1;
        store_register(2'd0, 8'hf1, 8'h11);
        load_immediate(2'd1, v);
        load_immediate(2'd2, v);
        alu_instruction(op_sub, 2'd3, 2'd1, 2'd2); // Zero set so BNE falls through
        branch_not_zero(fill_ptr + 8'd4);
        store_register(2'd1, 8'hf2, v);
        store_register(2'd2, 8'hf3, v);
        load_immediate(2'd2, v ^ 8'h01);
        alu_instruction(op_sub, 2'd3, 2'd1, 2'd2); // Zero clear so BNE is taken
        branch_not_zero(fill_ptr + 8'd4);
        path_on = 1'b0;
        store_register(2'd1, 8'hf4, v);
        path_on = 1'b1;
        store_register(2'd2, 8'hf5, v ^ 8'h01);
        run_program();
    endtask

    initial begin
        arst_n      = 1'b0;
        cycle_count = 0;
        lfsr_state  = 16'd15772;
        reset_fetch_test();
        load_store_test();
        alu_test();
        direct_load_test();
        branch_test();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
rtl/cpu_pkg.sv
rtl/control_unit.sv
rtl/fetch_unit.sv
rtl/register_file.sv
rtl/alu.sv
rtl/cpu_top.sv
bench/cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 --top-module cpu_tb -f files.f

./obj_dir/Vcpu_tb 2>&1 | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
